// File: design/usb_cmd_cfg.svh
`ifndef USB_CMD_CFG_SVH
`define USB_CMD_CFG_SVH

// ========================================
// Command opcodes
// ========================================
`define USB_CMD_OP_MASS     8'h01        // Send back N pattern bytes
`define USB_CMD_OP_WRITE    8'h02        // Write one control register
`define USB_CMD_OP_READ     8'h03        // Read one control register

// ========================================
// Widths
// ========================================
`define USB_CMD_DATA_W      32           // Reply word and register width
`define USB_CMD_KEEP_W      4            // One keep bit per reply byte
`define USB_CMD_REG_ADDR_W  15           // Register byte address

// Constant register values
`define USB_CMD_ID_VALUE    32'h55534231 // "USB1" in ASCII
`define USB_CMD_BAD_READ    32'hDEADBEEF // Returned for unmapped reads

// Register map, byte offsets
`define USB_CMD_OFS_ID      15'h0000
`define USB_CMD_OFS_SCRATCH 15'h0004
`define USB_CMD_OFS_SIZE    15'h0008
`define USB_CMD_OFS_CTRL    15'h000C
`define USB_CMD_OFS_STATUS  15'h0010

`endif

// File: design/usb_cmd_pkg.sv
`include "usb_cmd_cfg.svh"

package usb_cmd_pkg;

    // Register address as carried in the command argument
    typedef struct packed {
        logic [`USB_CMD_DATA_W-`USB_CMD_REG_ADDR_W-1:0] rsvd; // Upper bits, ignored
        logic [`USB_CMD_REG_ADDR_W-1:0]                 addr; // Byte offset
    } reg_addr_t;

    // Same argument word, two meanings picked by opcode
    typedef union packed {
        logic [`USB_CMD_DATA_W-1:0] mass_len; // TX_MASS byte count
        reg_addr_t                  reg_addr; // REG_WRITE / REG_READ target
    } cmd_arg_u;

    // One parsed command, held stable during req
    typedef struct packed {
        logic [7:0]                 opcode;
        cmd_arg_u                   arg;
        logic [`USB_CMD_DATA_W-1:0] wdata;    // Only meaningful for REG_WRITE
    } cmd_req_t;

    // Reply stream beat
    typedef struct packed {
        logic [`USB_CMD_DATA_W-1:0] data;
        logic [`USB_CMD_KEEP_W-1:0] keep;     // Lane 0 is the first byte
        logic                       last;     // Final beat of a reply
    } tx_word_t;

    // Write status byte
    typedef enum logic [7:0] {
        RESP_OKAY   = 8'h00,
        RESP_SLVERR = 8'h02
    } resp_code_e;

    // Memory test control, bit 0 upward
    typedef struct packed {
        logic [28:0] rsvd;
        logic        x16_en;
        logic        lfsr_en;
        logic        start;
    } memtest_ctrl_t;

    // Device status pins
    typedef struct packed {
        logic [27:0] rsvd;
        logic        memtest_fail;
        logic        memtest_done;
        logic        cfg_done;
        logic        pll_lock;
    } dev_status_t;

endpackage

// File: design/cmd_parser.sv
`timescale 1ns/1ps
`include "usb_cmd_cfg.svh"

module cmd_parser (
    input  logic                  regACLK,
    input  logic                  i_reset,
    // Host byte stream
    input  logic                  i_rx_valid,
    input  logic [7:0]            i_rx_data,
    output logic                  o_rx_ready,
    // Dispatch to the workers
    output usb_cmd_pkg::cmd_req_t o_cmd,
    output logic                  o_mass_req,
    input  logic                  i_mass_ack,
    output logic                  o_reg_req,
    input  logic                  i_reg_ack
);

    localparam logic [1:0] ST_OP   = 2'd0; // Waiting for an opcode byte
    localparam logic [1:0] ST_BODY = 2'd1; // Argument and data bytes
    localparam logic [1:0] ST_REQ  = 2'd2; // req high, waiting for ack
    localparam logic [1:0] ST_DONE = 2'd3; // req low, waiting for ack to drop

    logic [1:0]            state;
    logic [2:0]            byte_cnt;  // Body byte index, 0..7
    logic                  rx_fire;
    logic                  known_op;
    logic                  is_mass;
    logic                  is_write;
    logic                  frame_end;
    logic                  sel_ack;
    usb_cmd_pkg::cmd_req_t cmd_q;

    assign o_rx_ready = (state == ST_OP) || (state == ST_BODY); // Stall while in flight
    assign rx_fire    = i_rx_valid && o_rx_ready;
    assign known_op   = (i_rx_data == `USB_CMD_OP_MASS)  ||
                        (i_rx_data == `USB_CMD_OP_WRITE) ||
                        (i_rx_data == `USB_CMD_OP_READ);
    assign is_mass    = cmd_q.opcode == `USB_CMD_OP_MASS;
    assign is_write   = cmd_q.opcode == `USB_CMD_OP_WRITE;
    // Write frames carry four extra data bytes
    assign frame_end  = byte_cnt == (is_write ? 3'd7 : 3'd3);
    assign sel_ack    = is_mass ? i_mass_ack : i_reg_ack;
    assign o_cmd      = cmd_q;

    // ========================================
    // Frame capture
    // ========================================
    // Bytes arrive lowest first, so shift in from the top
    always_ff @(posedge regACLK) begin
        if (rx_fire) begin
            if (state == ST_OP) begin
                cmd_q.opcode <= i_rx_data;
            end else if (byte_cnt[2]) begin
                cmd_q.wdata <= {i_rx_data, cmd_q.wdata[31:8]};           // Data bytes 4..7
            end else begin
                cmd_q.arg.mass_len <= {i_rx_data, cmd_q.arg.mass_len[31:8]}; // Arg bytes
            end
        end
    end

    // ========================================
    // Sequencing and four-phase handshake
    // ========================================
    always_ff @(posedge regACLK) begin
        if (i_reset) begin
            state      <= ST_OP;
            byte_cnt   <= '0;
            o_mass_req <= 1'b0;
            o_reg_req  <= 1'b0;
        end else begin
            case (state)
                ST_OP: begin
                    if (rx_fire && known_op) begin // Unknown opcodes are dropped here
                        state    <= ST_BODY;
                        byte_cnt <= '0;
                    end
                end
                ST_BODY: begin
                    if (rx_fire) begin
                        byte_cnt <= byte_cnt + 3'd1;
                        if (frame_end) begin
                            // Raise req on the link the opcode picks
                            state      <= ST_REQ;
                            o_mass_req <= is_mass;
                            o_reg_req  <= !is_mass;
                        end
                    end
                end
                ST_REQ: begin
                    if (sel_ack) begin
                        state      <= ST_DONE;
                        o_mass_req <= 1'b0;
                        o_reg_req  <= 1'b0;
                    end
                end
                ST_DONE: begin
                    if (!sel_ack) begin
                        state <= ST_OP;  // Link idle again
                    end
                end
                default: state <= ST_OP;
            endcase
        end
    end

endmodule

// File: design/mass_sender.sv
`timescale 1ns/1ps
`include "usb_cmd_cfg.svh"

module mass_sender (
    input  logic                  regACLK,
    input  logic                  i_reset,
    // Command link
    input  logic                  i_req,
    input  usb_cmd_pkg::cmd_req_t i_cmd,
    output logic                  o_ack,
    // Reply words to the combiner
    output logic                  o_valid,
    output usb_cmd_pkg::tx_word_t o_word,
    input  logic                  i_ready
);

    logic [`USB_CMD_DATA_W-1:0] remain;    // Bytes still to send
    logic [7:0]                 pat;       // Pattern value of lane 0
    logic                       last_word;
    logic [`USB_CMD_KEEP_W:0]   keep_ext;  // One bit wider for the shift
    logic                       start;

    assign start     = i_req && !o_ack && !o_valid;
    assign last_word = remain <= `USB_CMD_DATA_W'(`USB_CMD_KEEP_W);

    // Reply word built from the counters, stable under back-pressure
    always_comb begin
        keep_ext = (5'd1 << remain[2:0]) - 5'd1;       // 1..4 bytes left
        o_word.keep = last_word ? keep_ext[`USB_CMD_KEEP_W-1:0] : '1;
        o_word.last = last_word;
        for (int i = 0; i < `USB_CMD_KEEP_W; i++) begin
            // Byte k carries k mod 256, unused lanes zero
            o_word.data[8*i +: 8] = o_word.keep[i] ? pat + 8'(i) : 8'h00;
        end
    end

    // Byte counters
    always_ff @(posedge regACLK) begin
        if (start) begin
            remain <= i_cmd.arg.mass_len;
            pat    <= 8'h00;
        end else if (o_valid && i_ready) begin
            remain <= remain - `USB_CMD_DATA_W'(`USB_CMD_KEEP_W);
            pat    <= pat + 8'(`USB_CMD_KEEP_W); // Wraps mod 256
        end
    end

    // Handshake control
    always_ff @(posedge regACLK) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_ack   <= 1'b0;
        end else if (o_ack) begin
            if (!i_req) begin
                o_ack <= 1'b0;   // Phase 4
            end
        end else if (o_valid) begin
            if (i_ready && last_word) begin
                o_valid <= 1'b0;
                o_ack   <= 1'b1; // Last word taken
            end
        end else if (i_req) begin
            // Zero length acks without a word
            if (i_cmd.arg.mass_len == '0) begin
                o_ack <= 1'b1;
            end else begin
                o_valid <= 1'b1;
            end
        end
    end

endmodule

// File: design/reg_agent.sv
`timescale 1ns/1ps
`include "usb_cmd_cfg.svh"

module reg_agent (
    input  logic                       regACLK,
    input  logic                       i_reset,
    // Command link
    input  logic                       i_req,
    input  usb_cmd_pkg::cmd_req_t      i_cmd,
    output logic                       o_ack,
    // Reply word to the combiner
    output logic                       o_valid,
    output usb_cmd_pkg::tx_word_t      o_word,
    input  logic                       i_ready,
    // Register pins
    input  usb_cmd_pkg::dev_status_t   i_status,
    output usb_cmd_pkg::memtest_ctrl_t o_memtest_ctrl,
    output logic [`USB_CMD_DATA_W-1:0] o_memtest_size
);

    logic [`USB_CMD_DATA_W-1:0]    scratch_q;
    logic [`USB_CMD_DATA_W-1:0]    size_q;
    usb_cmd_pkg::memtest_ctrl_t    ctrl_q;
    usb_cmd_pkg::dev_status_t      status_q;
    logic [`USB_CMD_REG_ADDR_W-1:0] addr;
    logic                          start;
    logic                          is_write;
    logic                          mapped;
    logic [`USB_CMD_DATA_W-1:0]    rd_data;
    usb_cmd_pkg::resp_code_e       resp;
    usb_cmd_pkg::tx_word_t         reply;
    usb_cmd_pkg::tx_word_t         word_q;

    assign addr           = i_cmd.arg.reg_addr.addr; // Address view of the argument
    assign is_write       = i_cmd.opcode == `USB_CMD_OP_WRITE;
    assign start          = i_req && !o_ack && !o_valid;
    assign o_word         = word_q;
    assign o_memtest_ctrl = ctrl_q;
    assign o_memtest_size = size_q;

    // ========================================
    // Address decode and reply build
    // ========================================
    always_comb begin
        mapped = 1'b1;
        case (addr)
            `USB_CMD_OFS_ID:      rd_data = `USB_CMD_ID_VALUE;
            `USB_CMD_OFS_SCRATCH: rd_data = scratch_q;
            `USB_CMD_OFS_SIZE:    rd_data = size_q;
            `USB_CMD_OFS_CTRL:    rd_data = ctrl_q;
            `USB_CMD_OFS_STATUS:  rd_data = status_q;
            default: begin
                rd_data = `USB_CMD_BAD_READ;
                mapped  = 1'b0;
            end
        endcase
        resp = mapped ? usb_cmd_pkg::RESP_OKAY : usb_cmd_pkg::RESP_SLVERR;
        if (is_write) begin
            reply.data = {24'h0, resp}; // Single status byte
            reply.keep = 4'b0001;
        end else begin
            reply.data = rd_data;
            reply.keep = 4'b1111;
        end
        reply.last = 1'b1;              // Always a one-word reply
    end

    // Status pins sampled every clock
    always_ff @(posedge regACLK) begin
        status_q <= i_status;
    end

    // Reply payload captured at command start
    always_ff @(posedge regACLK) begin
        if (start) begin
            word_q <= reply;
        end
    end

    // Writable registers, ID and status are read-only
    always_ff @(posedge regACLK) begin
        if (i_reset) begin
            scratch_q <= '0;
            size_q    <= '0;
            ctrl_q    <= '0;
        end else if (start && is_write) begin
            if (addr == `USB_CMD_OFS_SCRATCH) scratch_q <= i_cmd.wdata;
            if (addr == `USB_CMD_OFS_SIZE)    size_q    <= i_cmd.wdata;
            if (addr == `USB_CMD_OFS_CTRL)    ctrl_q    <= usb_cmd_pkg::memtest_ctrl_t'(i_cmd.wdata);
        end
    end

    // Handshake, ack only once the reply word is taken
    always_ff @(posedge regACLK) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_ack   <= 1'b0;
        end else if (start) begin
            o_valid <= 1'b1;
        end else if (o_valid && i_ready) begin
            o_valid <= 1'b0;
            o_ack   <= 1'b1;
        end else if (o_ack && !i_req) begin
            o_ack <= 1'b0;
        end
    end

endmodule

// File: design/tx_combiner.sv
`timescale 1ns/1ps

module tx_combiner (
    input  logic                  regACLK,
    input  logic                  i_reset,
    // Mass sender side
    input  logic                  i_mass_valid,
    input  usb_cmd_pkg::tx_word_t i_mass_word,
    output logic                  o_mass_ready,
    // Register agent side
    input  logic                  i_reg_valid,
    input  usb_cmd_pkg::tx_word_t i_reg_word,
    output logic                  o_reg_ready,
    // Merged output stream
    output logic                  o_tx_valid,
    output usb_cmd_pkg::tx_word_t o_tx_word,
    input  logic                  i_tx_ready
);

    logic locked;    // Holding a source until its last word
    logic lock_mass; // Locked source is the mass sender
    logic sel_mass;  // Current selection

    // Unlocked, mass wins a tie
    assign sel_mass     = locked ? lock_mass : i_mass_valid;
    assign o_tx_valid   = sel_mass ? i_mass_valid : i_reg_valid;
    assign o_tx_word    = sel_mass ? i_mass_word : i_reg_word;
    assign o_mass_ready = i_tx_ready && sel_mass;
    assign o_reg_ready  = i_tx_ready && !sel_mass; // Other source sees ready low

    // Lock register
    always_ff @(posedge regACLK) begin
        if (i_reset) begin
            locked    <= 1'b0;
            lock_mass <= 1'b0;
        end else if (o_tx_valid) begin
            lock_mass <= sel_mass;
            locked    <= !(i_tx_ready && o_tx_word.last); // Release on accepted last
        end
    end

endmodule

// File: design/usb_cmd_top.sv
`timescale 1ns/1ps
`include "usb_cmd_cfg.svh"

module usb_cmd_top (
    input  logic                       regACLK,
    input  logic                       i_reset,
    // Host byte stream
    input  logic                       i_rx_valid,
    input  logic [7:0]                 i_rx_data,
    output logic                       o_rx_ready,
    // Reply word stream
    output logic                       o_tx_valid,
    output usb_cmd_pkg::tx_word_t      o_tx_word,
    input  logic                       i_tx_ready,
    // Status and control pins
    input  usb_cmd_pkg::dev_status_t   i_status,
    output usb_cmd_pkg::memtest_ctrl_t o_memtest_ctrl,
    output logic [`USB_CMD_DATA_W-1:0] o_memtest_size
);

    // ========================================
    // Parser to worker links
    // ========================================
    usb_cmd_pkg::cmd_req_t cmd;
    logic                  mass_req;
    logic                  mass_ack;
    logic                  reg_req;
    logic                  reg_ack;

    // Worker reply streams
    logic                  mass_valid;
    usb_cmd_pkg::tx_word_t mass_word;
    logic                  mass_ready;
    logic                  reg_valid;
    usb_cmd_pkg::tx_word_t reg_word;
    logic                  reg_ready;

    cmd_parser u_cmd_parser (
        .regACLK    (regACLK),
        .i_reset    (i_reset),
        .i_rx_valid (i_rx_valid),
        .i_rx_data  (i_rx_data),
        .o_rx_ready (o_rx_ready),
        .o_cmd      (cmd),
        .o_mass_req (mass_req),
        .i_mass_ack (mass_ack),
        .o_reg_req  (reg_req),
        .i_reg_ack  (reg_ack)
    );

    mass_sender u_mass_sender (
        .regACLK (regACLK),
        .i_reset (i_reset),
        .i_req   (mass_req),
        .i_cmd   (cmd),
        .o_ack   (mass_ack),
        .o_valid (mass_valid),
        .o_word  (mass_word),
        .i_ready (mass_ready)
    );

    reg_agent u_reg_agent (
        .regACLK        (regACLK),
        .i_reset        (i_reset),
        .i_req          (reg_req),
        .i_cmd          (cmd),
        .o_ack          (reg_ack),
        .o_valid        (reg_valid),
        .o_word         (reg_word),
        .i_ready        (reg_ready),
        .i_status       (i_status),
        .o_memtest_ctrl (o_memtest_ctrl),
        .o_memtest_size (o_memtest_size)
    );

    tx_combiner u_tx_combiner (
        .regACLK      (regACLK),
        .i_reset      (i_reset),
        .i_mass_valid (mass_valid),
        .i_mass_word  (mass_word),
        .o_mass_ready (mass_ready),
        .i_reg_valid  (reg_valid),
        .i_reg_word   (reg_word),
        .o_reg_ready  (reg_ready),
        .o_tx_valid   (o_tx_valid),
        .o_tx_word    (o_tx_word),
        .i_tx_ready   (i_tx_ready)
    );

endmodule

// File: verif/usb_cmd_assert.sv
`timescale 1ns/1ps

module usb_cmd_assert (
    input logic                  regACLK,
    input logic                  i_reset,
    input logic                  i_mass_req,
    input logic                  i_mass_ack,
    input logic                  i_reg_req,
    input logic                  i_reg_ack,
    input logic                  i_tx_valid,
    input usb_cmd_pkg::tx_word_t i_tx_word,
    input logic                  i_tx_ready
);

    // ========================================
    // Four-phase req/ack links
    // ========================================
    a_tx_in_cmd: assert property (@(posedge regACLK) disable iff (i_reset)
        i_tx_valid |-> (i_mass_req || i_reg_req))
        else $error("Reply word offered with no command in flight");

    a_mass_req_hold: assert property (@(posedge regACLK) disable iff (i_reset)
        i_mass_req && !i_mass_ack |=> i_mass_req)
        else $error("mass_req dropped before mass_ack");

    a_mass_ack_hold: assert property (@(posedge regACLK) disable iff (i_reset)
        i_mass_ack && i_mass_req |=> i_mass_ack)
        else $error("mass_ack dropped while mass_req was high");

    a_reg_req_hold: assert property (@(posedge regACLK) disable iff (i_reset)
        i_reg_req && !i_reg_ack |=> i_reg_req)
        else $error("reg_req dropped before reg_ack");

    a_reg_ack_hold: assert property (@(posedge regACLK) disable iff (i_reset)
        i_reg_ack && i_reg_req |=> i_reg_ack)
        else $error("reg_ack dropped while reg_req was high");

    // Reply word held under back-pressure
    a_tx_stable: assert property (@(posedge regACLK) disable iff (i_reset)
        i_tx_valid && !i_tx_ready |=> i_tx_valid && $stable(i_tx_word))
        else $error("Transmit word changed or valid dropped while stalled");

endmodule

bind usb_cmd_top usb_cmd_assert u_usb_cmd_assert (
    .regACLK    (regACLK),
    .i_reset    (i_reset),
    .i_mass_req (mass_req),
    .i_mass_ack (mass_ack),
    .i_reg_req  (reg_req),
    .i_reg_ack  (reg_ack),
    .i_tx_valid (o_tx_valid),
    .i_tx_word  (o_tx_word),
    .i_tx_ready (i_tx_ready)
);

// File: verif/tb_usb_cmd.sv
`timescale 1ns/1ps
`include "usb_cmd_cfg.svh"

module tb_usb_cmd;

    localparam logic [31:0] SEED    = 32'd66635;
    localparam int          N_CMDS  = 300;  // Random commands after the directed ones
    localparam int          TIMEOUT = 4000; // Cycles allowed per wait

    logic                       regACLK;
    logic                       i_reset;
    logic                       i_rx_valid;
    logic [7:0]                 i_rx_data;
    logic                       o_rx_ready;
    logic                       o_tx_valid;
    usb_cmd_pkg::tx_word_t      o_tx_word;
    logic                       i_tx_ready;
    usb_cmd_pkg::dev_status_t   i_status;
    usb_cmd_pkg::memtest_ctrl_t o_memtest_ctrl;
    logic [`USB_CMD_DATA_W-1:0] o_memtest_size;

    // Reference model state
    logic [31:0]                host_lcg;
    logic [31:0]                scratch_m;
    logic [31:0]                size_m;
    usb_cmd_pkg::memtest_ctrl_t ctrl_m;
    usb_cmd_pkg::dev_status_t   status_m;
    usb_cmd_pkg::tx_word_t      exp_q[$];   // Predicted reply words, in order
    logic                       fail_shown;
    logic                       run_done;
    int                         words_seen;

    usb_cmd_top i_dut (
        .regACLK        (regACLK),
        .i_reset        (i_reset),
        .i_rx_valid     (i_rx_valid),
        .i_rx_data      (i_rx_data),
        .o_rx_ready     (o_rx_ready),
        .o_tx_valid     (o_tx_valid),
        .o_tx_word      (o_tx_word),
        .i_tx_ready     (i_tx_ready),
        .i_status       (i_status),
        .o_memtest_ctrl (o_memtest_ctrl),
        .o_memtest_size (o_memtest_size)
    );

    initial begin
        regACLK = 1'b0;
        forever #50 regACLK = ~regACLK; // 100 ns period
    end

    // ========================================
    // Random numbers and reporting
    // ========================================
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Uniform-ish pick in 0..n-1 from the upper LCG bits
    function automatic logic [31:0] host_pick(input logic [31:0] n);
        host_lcg = lcg_step(host_lcg);
        return {16'h0, host_lcg[31:16]} % n;
    endfunction

    function automatic logic [31:0] host_data();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = host_pick(32'h10000);
        lo = host_pick(32'h10000);
        return {hi[15:0], lo[15:0]};
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        fail_shown = 1'b1;
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_tx_word(input usb_cmd_pkg::tx_word_t got,
                                 input usb_cmd_pkg::tx_word_t exp);
        if (got.data !== exp.data)
            fail_now($sformatf("Mismatch o_tx_word.data got %h expected %h", got.data, exp.data));
        if (got.keep !== exp.keep)
            fail_now($sformatf("Mismatch o_tx_word.keep got %h expected %h", got.keep, exp.keep));
        if (got.last !== exp.last)
            fail_now($sformatf("Mismatch o_tx_word.last got %h expected %h", got.last, exp.last));
    endtask

    task automatic check_ctrl(input usb_cmd_pkg::memtest_ctrl_t got_ctrl,
                              input usb_cmd_pkg::memtest_ctrl_t exp_ctrl,
                              input logic [31:0]                got_size,
                              input logic [31:0]                exp_size);
        if (got_ctrl !== exp_ctrl)
            fail_now($sformatf("Mismatch o_memtest_ctrl got %h expected %h", got_ctrl, exp_ctrl));
        if (got_size !== exp_size)
            fail_now($sformatf("Mismatch o_memtest_size got %h expected %h", got_size, exp_size));
    endtask

    // ========================================
    // Clocking, drive and reply sink
    // ========================================
    // Inputs change on the falling edge, outputs are read 1 ns later
    task automatic next_cycle(input logic rx_v, input logic [7:0] rx_d);
        @(negedge regACLK);
        i_tx_ready = host_pick(4) != 0;  // Back-pressure about a quarter of the time
        i_rx_valid = rx_v;
        i_rx_data  = rx_d;
        i_status   = status_m;
        #1;
        if (!i_reset && o_tx_valid && i_tx_ready) begin // Taken on the coming rising edge
            if (exp_q.size() == 0) begin
                fail_now($sformatf("Reply word %h arrived with no reply pending", o_tx_word.data));
            end else begin
                check_tx_word(o_tx_word, exp_q.pop_front());
            end
            words_seen++;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        int gaps;
        int cnt;
        gaps = 0;
        cnt  = 0;
        while (gaps < 3 && host_pick(4) == 0) begin // Random idle gap before the byte
            next_cycle(1'b0, 8'h00);
            gaps++;
        end
        next_cycle(1'b1, b);
        while (!o_rx_ready) begin                    // Valid held until accepted
            cnt++;
            if (cnt > TIMEOUT) fail_now("Timeout waiting for the DUT to accept a host byte");
            next_cycle(1'b1, b);
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int i = 0; i < 4; i++) begin
            send_byte(w[8*i +: 8]); // Lowest byte first
        end
    endtask

    // Wait until the last command has finished and all replies are in
    task automatic drain();
        int cnt;
        cnt = 0;
        next_cycle(1'b0, 8'h00);
        while (!o_rx_ready) begin
            cnt++;
            if (cnt > TIMEOUT) fail_now("Timeout waiting for the command in flight to finish");
            next_cycle(1'b0, 8'h00);
        end
        if (exp_q.size() != 0)
            fail_now($sformatf("Command finished with %0d reply words missing", exp_q.size()));
        check_ctrl(o_memtest_ctrl, ctrl_m, o_memtest_size, size_m);
    endtask

    // ========================================
    // Register model and commands
    // ========================================
    function automatic logic is_mapped(input logic [`USB_CMD_REG_ADDR_W-1:0] addr);
        return addr inside {`USB_CMD_OFS_ID, `USB_CMD_OFS_SCRATCH, `USB_CMD_OFS_SIZE,
                            `USB_CMD_OFS_CTRL, `USB_CMD_OFS_STATUS};
    endfunction

    function automatic logic [31:0] model_read(input logic [`USB_CMD_REG_ADDR_W-1:0] addr);
        case (addr)
            `USB_CMD_OFS_ID:      return `USB_CMD_ID_VALUE;
            `USB_CMD_OFS_SCRATCH: return scratch_m;
            `USB_CMD_OFS_SIZE:    return size_m;
            `USB_CMD_OFS_CTRL:    return ctrl_m;
            `USB_CMD_OFS_STATUS:  return status_m;
            default:              return `USB_CMD_BAD_READ;
        endcase
    endfunction

    function automatic logic [`USB_CMD_REG_ADDR_W-1:0] pick_addr();
        logic [31:0] sel;
        logic [31:0] ofs;
        sel = host_pick(6);
        ofs = host_pick(64);
        case (sel)
            32'd0:   return `USB_CMD_OFS_ID;
            32'd1:   return `USB_CMD_OFS_SCRATCH;
            32'd2:   return `USB_CMD_OFS_SIZE;
            32'd3:   return `USB_CMD_OFS_CTRL;
            32'd4:   return `USB_CMD_OFS_STATUS;
            default: return 15'h0100 | 15'(ofs << 2); // Unmapped window 0x100..0x1FC
        endcase
    endfunction

    task automatic do_mass(input int len);
        usb_cmd_pkg::tx_word_t w;
        int                    k;
        for (int base = 0; base < len; base += 4) begin
            w = '0;
            for (int i = 0; i < 4; i++) begin
                k = base + i;
                if (k < len) begin
                    w.keep[i]        = 1'b1;
                    w.data[8*i +: 8] = k[7:0]; // Pattern byte k mod 256
                end
            end
            w.last = (base + 4) >= len;
            exp_q.push_back(w);
        end
        send_byte(`USB_CMD_OP_MASS);
        send_word(32'(len));
    endtask

    task automatic do_write(input logic [`USB_CMD_REG_ADDR_W-1:0] addr, input logic [31:0] data);
        usb_cmd_pkg::tx_word_t   w;
        usb_cmd_pkg::resp_code_e resp;
        resp   = is_mapped(addr) ? usb_cmd_pkg::RESP_OKAY : usb_cmd_pkg::RESP_SLVERR;
        w.data = {24'h0, resp};
        w.keep = 4'b0001;
        w.last = 1'b1;
        exp_q.push_back(w);
        case (addr)                          // ID and status stay as they are
            `USB_CMD_OFS_SCRATCH: scratch_m = data;
            `USB_CMD_OFS_SIZE:    size_m    = data;
            `USB_CMD_OFS_CTRL:    ctrl_m    = usb_cmd_pkg::memtest_ctrl_t'(data);
            default: ;
        endcase
        send_byte(`USB_CMD_OP_WRITE);
        send_word({17'h0, addr});
        send_word(data);
    endtask

    task automatic do_read(input logic [`USB_CMD_REG_ADDR_W-1:0] addr);
        usb_cmd_pkg::tx_word_t w;
        w.data = model_read(addr);
        w.keep = 4'b1111;
        w.last = 1'b1;
        exp_q.push_back(w);
        send_byte(`USB_CMD_OP_READ);
        send_word({17'h0, addr});
    endtask

    task automatic do_unknown();
        logic [7:0] b;
        b = 8'(host_pick(256));
        if (b >= 8'h01 && b <= 8'h03) b = b + 8'h40; // Keep it off the known opcodes
        send_byte(b);
    endtask

    // Pins change only with the DUT idle so a pending status read is not disturbed
    task automatic set_status(input logic [3:0] pins);
        drain();
        status_m = usb_cmd_pkg::dev_status_t'({28'h0, pins});
        next_cycle(1'b0, 8'h00);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int kind;
        host_lcg   = SEED;
        fail_shown = 1'b0;
        run_done   = 1'b0;
        words_seen = 0;
        scratch_m  = '0;
        size_m     = '0;
        ctrl_m     = '0;
        status_m   = '0;
        i_reset    = 1'b1;
        i_rx_valid = 1'b0;
        i_rx_data  = 8'h00;
        i_tx_ready = 1'b0;
        i_status   = '0;
        repeat (16) @(posedge regACLK);
        @(negedge regACLK);
        i_reset = 1'b0;
        #1;
        if (o_tx_valid !== 1'b0 || o_rx_ready !== 1'b1)
            fail_now("Stream handshake outputs are wrong after reset");
        check_ctrl(o_memtest_ctrl, ctrl_m, o_memtest_size, size_m);

        // Directed pass over each rule
        do_write(`USB_CMD_OFS_SCRATCH, 32'hA5C3_0F96);
        do_read(`USB_CMD_OFS_SCRATCH);
        do_write(`USB_CMD_OFS_CTRL, 32'h0000_0007);
        do_write(`USB_CMD_OFS_SIZE, 32'h0010_0000);
        do_read(`USB_CMD_OFS_ID);
        do_write(`USB_CMD_OFS_ID, 32'h1234_5678);
        do_read(`USB_CMD_OFS_ID);
        set_status(4'b1011);
        do_read(`USB_CMD_OFS_STATUS);
        do_write(`USB_CMD_OFS_STATUS, 32'hFFFF_FFFF);
        do_read(`USB_CMD_OFS_STATUS);
        do_write(15'h0100, 32'hCAFE_F00D);
        do_read(15'h0100);
        do_mass(0);
        do_mass(1);
        do_mass(4);
        do_mass(7);
        do_unknown();
        do_read(`USB_CMD_OFS_CTRL);
        drain();

        for (int n = 0; n < N_CMDS; n++) begin
            kind = int'(host_pick(16));
            if (kind < 5) begin
                do_mass(int'(host_pick(41)));
            end else if (kind < 9) begin
                do_write(pick_addr(), host_data());
            end else if (kind < 13) begin
                do_read(pick_addr());
            end else if (kind == 13) begin
                do_unknown();
            end else begin
                set_status(4'(host_pick(16)));
            end
        end
        drain();
        $display("Run complete, %0d reply words checked", words_seen);
        run_done = 1'b1;
        $display("No errors");
        $finish;
    end

    // A run stopped by a failed assertion still ends with the fail line
    final begin
        if (!run_done && !fail_shown) begin
            $display("Errors found");
        end
    end

endmodule

// File: all.f
+incdir+design
design/usb_cmd_pkg.sv
design/cmd_parser.sv
design/mass_sender.sv
design/reg_agent.sv
design/tx_combiner.sv
design/usb_cmd_top.sv
verif/usb_cmd_assert.sv
verif/tb_usb_cmd.sv

// File: Makefile
# Verilator build for the USB command engine testbench
VERILATOR ?= verilator
TOP       ?= tb_usb_cmd
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# Pass only if the simulation output holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
